// File: rtl/exu_cfg_pkg.sv
package exu_cfg_pkg;

    // data path width
    localparam int XLEN = 32;

    // register file index width
    localparam int REG_ADDR_W = 5;

    // shift amount taken from the low bits of op2
    localparam int SHAMT_W = 5;

    // one quotient bit per iteration
    localparam int DIV_STEPS = XLEN;

    // iteration counter, counts 0 .. DIV_STEPS
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

endpackage

// File: rtl/exu_dec_pkg.sv
package exu_dec_pkg;

    localparam int GRP_W      = 3;
    localparam int DEC_INFO_W = 16;

    // number of one-hot alu ops
    localparam int ALU_OP_W = 12;

    // instruction groups
    localparam logic [GRP_W-1:0] GRP_NONE = 3'd0;
    localparam logic [GRP_W-1:0] GRP_ALU  = 3'd1;
    localparam logic [GRP_W-1:0] GRP_DIV  = 3'd2;

    // alu view, group field on top
    typedef struct packed {
        logic [GRP_W-1:0] grp;
        logic             op2_imm;
        logic             op_lui;
        logic             op_auipc;
        logic             op_add;
        logic             op_sub;
        logic             op_sll;
        logic             op_slt;
        logic             op_sltu;
        logic             op_xor;
        logic             op_srl;
        logic             op_sra;
        logic             op_or;
        logic             op_and;
    } alu_info_t;

    // division view, same group position as the alu view
    typedef struct packed {
        logic [GRP_W-1:0]              grp;
        logic                          op_div;
        logic                          op_divu;
        logic                          op_rem;
        logic                          op_remu;
        logic [DEC_INFO_W-GRP_W-5:0]   rsvd;
    } div_info_t;

    // one decoded word, read through the view its group selects
    typedef union packed {
        alu_info_t alu;
        div_info_t div;
    } dec_info_u;

    // one-hot division op, bit 3 div, bit 2 divu, bit 1 rem, bit 0 remu
    typedef logic [3:0] div_op_t;

endpackage

// File: rtl/exu_dispatch.sv
`timescale 1ns/10ps

module exu_dispatch
    import exu_cfg_pkg::*;
    import exu_dec_pkg::*;
(
    input  dec_info_u             dec_info_i,
    input  logic [XLEN-1:0]       dec_imm_i,
    input  logic [XLEN-1:0]       dec_pc_i,
    input  logic [XLEN-1:0]       rs1_rdata_i,
    input  logic [XLEN-1:0]       rs2_rdata_i,
    output logic                  req_alu_o,
    output logic [XLEN-1:0]       alu_op1_o,
    output logic [XLEN-1:0]       alu_op2_o,
    output logic [ALU_OP_W-1:0]   alu_sel_o,
    output logic                  req_div_o,
    output logic [XLEN-1:0]       div_op1_o,
    output logic [XLEN-1:0]       div_op2_o,
    output div_op_t               div_op_o
);

    alu_info_t           alu_view;
    div_info_t           div_view;
    logic                is_alu;
    logic                is_div;
    logic [ALU_OP_W-1:0] alu_ops;

    assign alu_view = dec_info_i.alu;
    assign div_view = dec_info_i.div;

    // group field lines up in both views
    assign is_alu = (alu_view.grp == GRP_ALU);
    assign is_div = (div_view.grp == GRP_DIV);

    assign alu_ops = {alu_view.op_lui, alu_view.op_auipc, alu_view.op_add, alu_view.op_sub,
                      alu_view.op_sll, alu_view.op_slt,   alu_view.op_sltu, alu_view.op_xor,
                      alu_view.op_srl, alu_view.op_sra,   alu_view.op_or,  alu_view.op_and};

    assign req_alu_o = is_alu;
    assign alu_sel_o = is_alu ? alu_ops : '0;

    // operand select, lui and auipc reuse the adder
    always_comb begin
        if (alu_view.op_lui) begin
            alu_op1_o = '0;
            alu_op2_o = dec_imm_i;
        end else if (alu_view.op_auipc) begin
            alu_op1_o = dec_pc_i;
            alu_op2_o = dec_imm_i;
        end else begin
            alu_op1_o = rs1_rdata_i;
            alu_op2_o = alu_view.op2_imm ? dec_imm_i : rs2_rdata_i;
        end
    end

    // division always takes both source registers
    assign req_div_o = is_div;
    assign div_op1_o = rs1_rdata_i;
    assign div_op2_o = rs2_rdata_i;
    assign div_op_o  = is_div ? {div_view.op_div, div_view.op_divu,
                                 div_view.op_rem, div_view.op_remu} : '0;

    // decoder must hand over exactly one alu op
    always_comb begin
        if (is_alu) begin
            assert ($onehot(alu_ops))
                else $error("alu op bits not one-hot: %b", alu_ops);
        end
    end

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/10ps

module exu_alu
    import exu_cfg_pkg::*;
    import exu_dec_pkg::*;
(
    input  logic                  req_alu_i,
    input  logic [XLEN-1:0]       alu_op1_i,
    input  logic [XLEN-1:0]       alu_op2_i,
    input  logic [ALU_OP_W-1:0]   alu_sel_i,
    input  logic [REG_ADDR_W-1:0] alu_rd_i,
    output logic [XLEN-1:0]       result_o,
    output logic                  reg_we_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o
);

    logic               op_lui;
    logic               op_auipc;
    logic               op_add;
    logic               op_sub;
    logic               op_sll;
    logic               op_slt;
    logic               op_sltu;
    logic               op_xor;
    logic               op_srl;
    logic               op_sra;
    logic               op_or;
    logic               op_and;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    diff;
    logic               lt_s;
    logic               lt_u;

    assign {op_lui, op_auipc, op_add, op_sub, op_sll, op_slt,
            op_sltu, op_xor, op_srl, op_sra, op_or, op_and} = alu_sel_i;

    assign shamt = alu_op2_i[SHAMT_W-1:0];

    // lui and auipc arrive with op1 already zero or pc
    assign sum  = alu_op1_i + alu_op2_i;
    assign diff = alu_op1_i - alu_op2_i;
    assign lt_s = $signed(alu_op1_i) < $signed(alu_op2_i);
    assign lt_u = alu_op1_i < alu_op2_i;

    always_comb begin
        if (op_lui || op_auipc || op_add) begin
            result_o = sum;
        end else if (op_sub) begin
            result_o = diff;
        end else if (op_sll) begin
            result_o = alu_op1_i << shamt;
        end else if (op_slt) begin
            result_o = {{(XLEN-1){1'b0}}, lt_s};
        end else if (op_sltu) begin
            result_o = {{(XLEN-1){1'b0}}, lt_u};
        end else if (op_xor) begin
            result_o = alu_op1_i ^ alu_op2_i;
        end else if (op_srl) begin
            result_o = alu_op1_i >> shamt;
        end else if (op_sra) begin
            result_o = $signed(alu_op1_i) >>> shamt;
        end else if (op_or) begin
            result_o = alu_op1_i | alu_op2_i;
        end else if (op_and) begin
            result_o = alu_op1_i & alu_op2_i;
        end else begin
            result_o = '0;
        end
    end

    assign reg_we_o    = req_alu_i;
    assign reg_waddr_o = alu_rd_i;

endmodule

// File: rtl/exu_div_ctrl.sv
`timescale 1ns/10ps

module exu_div_ctrl
    import exu_cfg_pkg::*;
    import exu_dec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  req_div_i,
    input  logic [XLEN-1:0]       div_op1_i,
    input  logic [XLEN-1:0]       div_op2_i,
    input  div_op_t               div_op_i,
    input  logic [REG_ADDR_W-1:0] reg_waddr_i,
    input  logic                  div_ready_i,
    input  logic                  div_busy_i,
    input  logic [XLEN-1:0]       div_result_i,
    output logic                  div_start_o,
    output logic [XLEN-1:0]       div_dividend_o,
    output logic [XLEN-1:0]       div_divisor_o,
    output div_op_t               div_op_o,
    output logic                  hold_flag_o,
    output logic [XLEN-1:0]       reg_wdata_o,
    output logic                  reg_we_o,
    output logic [REG_ADDR_W-1:0] reg_waddr_o
);

    logic                  pending_q;
    logic                  start_q;
    logic [XLEN-1:0]       dividend_q;
    logic [XLEN-1:0]       divisor_q;
    div_op_t               op_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  accept;

    // pending stays set through the write-back cycle,
    // so a request still on the inputs then is not taken twice
    assign accept = req_div_i && !pending_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pending_q <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                pending_q <= 1'b1;
            end else if (reg_we_o) begin
                pending_q <= 1'b0;
            end
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            dividend_q <= div_op1_i;
            divisor_q  <= div_op2_i;
            op_q       <= div_op_i;
            rd_q       <= reg_waddr_i;
        end
    end

    assign div_start_o    = start_q;
    assign div_dividend_o = dividend_q;
    assign div_divisor_o  = divisor_q;
    assign div_op_o       = op_q;

    // stall from first sight of the request until the divider lets go
    assign hold_flag_o = accept || start_q || div_busy_i;

    assign reg_we_o    = pending_q && div_ready_i;
    assign reg_wdata_o = div_result_i;
    assign reg_waddr_o = rd_q;

    // one write-back per division
    a_we_single: assert property (@(posedge clk) disable iff (rst_i)
        reg_we_o |=> !reg_we_o)
        else $error("div write-back high for two cycles");

    // divider must be idle when a start goes out
    a_start_idle: assert property (@(posedge clk) disable iff (rst_i)
        !(div_start_o && div_busy_i))
        else $error("div start issued while divider busy");

endmodule

// File: rtl/exu_div.sv
`timescale 1ns/10ps

module exu_div
    import exu_cfg_pkg::*;
    import exu_dec_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic            start_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    input  div_op_t         op_i,
    output logic [XLEN-1:0] result_o,
    output logic            ready_o,
    output logic            busy_o
);

    logic                 busy_q;
    logic                 ready_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]      quot_q;
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      divisor_q;
    logic                 neg_quot_q;
    logic                 neg_rem_q;
    logic                 want_rem_q;
    logic                 div_zero_q;
    logic [XLEN-1:0]      result_q;

    logic                 signed_op;
    logic                 neg_dividend;
    logic                 neg_divisor;
    logic [XLEN-1:0]      dividend_abs;
    logic [XLEN-1:0]      divisor_abs;
    logic                 last_step;
    logic [XLEN:0]        partial;
    logic [XLEN:0]        diff;
    logic [XLEN-1:0]      quot_fix;
    logic [XLEN-1:0]      rem_fix;

    // div and rem are the signed ops
    assign signed_op    = op_i[3] || op_i[1];
    assign neg_dividend = signed_op && dividend_i[XLEN-1];
    assign neg_divisor  = signed_op && divisor_i[XLEN-1];
    assign dividend_abs = neg_dividend ? -dividend_i : dividend_i;
    assign divisor_abs  = neg_divisor ? -divisor_i : divisor_i;

    assign last_step = (cnt_q == DIV_CNT_W'(DIV_STEPS));

    // shift in the next dividend bit and try the subtract
    assign partial = {rem_q, quot_q[XLEN-1]};
    assign diff    = partial - {1'b0, divisor_q};

    // most negative / -1 needs no special case
    // the magnitude 2^(XLEN-1) comes back unchanged with a positive sign
    // by zero the remainder already equals the dividend
    assign quot_fix = div_zero_q ? '1 : (neg_quot_q ? -quot_q : quot_q);
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            ready_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                if (last_step) begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + DIV_CNT_W'(1);
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start_i) begin
            quot_q     <= dividend_abs;
            rem_q      <= '0;
            divisor_q  <= divisor_abs;
            neg_quot_q <= neg_dividend ^ neg_divisor;
            neg_rem_q  <= neg_dividend;
            want_rem_q <= op_i[1] || op_i[0];
            div_zero_q <= (divisor_i == '0);
        end else if (busy_q && !last_step) begin
            quot_q <= {quot_q[XLEN-2:0], !diff[XLEN]};
            rem_q  <= diff[XLEN] ? partial[XLEN-1:0] : diff[XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q && last_step) begin
            result_q <= want_rem_q ? rem_fix : quot_fix;
        end
    end

    assign result_o = result_q;
    assign ready_o  = ready_q;
    assign busy_o   = busy_q;

    // result only after a busy phase of exactly DIV_STEPS+1 cycles
    a_ready_after_busy: assert property (@(posedge clk) disable iff (rst_i)
        ready_o |-> $past(busy_o) && $past(busy_o, DIV_STEPS + 1)
                    && !$past(busy_o, DIV_STEPS + 2))
        else $error("div ready without a full busy phase");

endmodule

// File: rtl/exu.sv
`timescale 1ns/10ps

module exu
    import exu_cfg_pkg::*;
    import exu_dec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  dec_info_u             dec_info_i,
    input  logic [XLEN-1:0]       dec_imm_i,
    input  logic [XLEN-1:0]       dec_pc_i,
    input  logic [XLEN-1:0]       rs1_rdata_i,
    input  logic [XLEN-1:0]       rs2_rdata_i,
    input  logic [REG_ADDR_W-1:0] reg_waddr_i,
    output logic [XLEN-1:0]       alu_reg_wdata_o,
    output logic                  alu_reg_we_o,
    output logic [REG_ADDR_W-1:0] alu_reg_waddr_o,
    output logic [XLEN-1:0]       muldiv_reg_wdata_o,
    output logic                  muldiv_reg_we_o,
    output logic [REG_ADDR_W-1:0] muldiv_reg_waddr_o,
    output logic                  hold_flag_o
);

    // dispatch to alu
    logic                req_alu;
    logic [XLEN-1:0]     alu_op1;
    logic [XLEN-1:0]     alu_op2;
    logic [ALU_OP_W-1:0] alu_sel;

    // dispatch to div controller
    logic                req_div;
    logic [XLEN-1:0]     div_op1;
    logic [XLEN-1:0]     div_op2;
    div_op_t             div_op;

    // controller and divider
    logic                div_start;
    logic [XLEN-1:0]     div_dividend;
    logic [XLEN-1:0]     div_divisor;
    div_op_t             div_op_q;
    logic [XLEN-1:0]     div_result;
    logic                div_ready;
    logic                div_busy;

    exu_dispatch u_exu_dispatch (
        .dec_info_i (dec_info_i),
        .dec_imm_i  (dec_imm_i),
        .dec_pc_i   (dec_pc_i),
        .rs1_rdata_i(rs1_rdata_i),
        .rs2_rdata_i(rs2_rdata_i),
        .req_alu_o  (req_alu),
        .alu_op1_o  (alu_op1),
        .alu_op2_o  (alu_op2),
        .alu_sel_o  (alu_sel),
        .req_div_o  (req_div),
        .div_op1_o  (div_op1),
        .div_op2_o  (div_op2),
        .div_op_o   (div_op)
    );

    exu_alu u_alu (
        .req_alu_i  (req_alu),
        .alu_op1_i  (alu_op1),
        .alu_op2_i  (alu_op2),
        .alu_sel_i  (alu_sel),
        .alu_rd_i   (reg_waddr_i),
        .result_o   (alu_reg_wdata_o),
        .reg_we_o   (alu_reg_we_o),
        .reg_waddr_o(alu_reg_waddr_o)
    );

    exu_div_ctrl u_div_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_div_i     (req_div),
        .div_op1_i     (div_op1),
        .div_op2_i     (div_op2),
        .div_op_i      (div_op),
        .reg_waddr_i   (reg_waddr_i),
        .div_ready_i   (div_ready),
        .div_busy_i    (div_busy),
        .div_result_i  (div_result),
        .div_start_o   (div_start),
        .div_dividend_o(div_dividend),
        .div_divisor_o (div_divisor),
        .div_op_o      (div_op_q),
        .hold_flag_o   (hold_flag_o),
        .reg_wdata_o   (muldiv_reg_wdata_o),
        .reg_we_o      (muldiv_reg_we_o),
        .reg_waddr_o   (muldiv_reg_waddr_o)
    );

    exu_div u_div (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (div_start),
        .dividend_i(div_dividend),
        .divisor_i (div_divisor),
        .op_i      (div_op_q),
        .result_o  (div_result),
        .ready_o   (div_ready),
        .busy_o    (div_busy)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 2;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset drops just after the second rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// File: verification/tb_exu.sv
`timescale 1ns/10ps

module tb_exu
    import exu_cfg_pkg::*;
    import exu_dec_pkg::*;
();

    localparam int SEED           = 72061;
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int DRIVE_DLY      = 1;
    localparam int DIV_MAX_WAIT   = DIV_STEPS + 4;

    // alu op index in the order of the one-hot field
    localparam int OP_LUI   = 0;
    localparam int OP_AUIPC = 1;
    localparam int OP_ADD   = 2;
    localparam int OP_SUB   = 3;
    localparam int OP_SLL   = 4;
    localparam int OP_SLT   = 5;
    localparam int OP_SLTU  = 6;
    localparam int OP_XOR   = 7;
    localparam int OP_SRL   = 8;
    localparam int OP_SRA   = 9;
    localparam int OP_OR    = 10;
    localparam int OP_AND   = 11;

    localparam int OP_DIV  = 0;
    localparam int OP_DIVU = 1;
    localparam int OP_REM  = 2;
    localparam int OP_REMU = 3;

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    string alu_names [ALU_OP_W] = '{"lui", "auipc", "add", "sub", "sll", "slt",
                                    "sltu", "xor", "srl", "sra", "or", "and"};
    string div_names [4] = '{"div", "divu", "rem", "remu"};

    logic                  clk;
    logic                  rst;
    dec_info_u             dec_info;
    logic [XLEN-1:0]       dec_imm;
    logic [XLEN-1:0]       dec_pc;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_wdata;
    logic                  alu_we;
    logic [REG_ADDR_W-1:0] alu_waddr;
    logic [XLEN-1:0]       md_wdata;
    logic                  md_we;
    logic [REG_ADDR_W-1:0] md_waddr;
    logic                  hold;
    int                    cycle_cnt = 0;

    tb_clk_gen u_clk_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    exu uut (
        .clk               (clk),
        .rst_i             (rst),
        .dec_info_i        (dec_info),
        .dec_imm_i         (dec_imm),
        .dec_pc_i          (dec_pc),
        .rs1_rdata_i       (rs1),
        .rs2_rdata_i       (rs2),
        .reg_waddr_i       (rd),
        .alu_reg_wdata_o   (alu_wdata),
        .alu_reg_we_o      (alu_we),
        .alu_reg_waddr_o   (alu_waddr),
        .muldiv_reg_wdata_o(md_wdata),
        .muldiv_reg_we_o   (md_we),
        .muldiv_reg_waddr_o(md_waddr),
        .hold_flag_o       (hold)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "run aborted by timeout");
        end
    end

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic dec_info_u alu_info(input int idx, input logic use_imm);
        dec_info_u info;
        info = '0;
        info.alu.grp = GRP_ALU;
        info.alu.op2_imm = use_imm;
        {info.alu.op_lui, info.alu.op_auipc, info.alu.op_add, info.alu.op_sub,
         info.alu.op_sll, info.alu.op_slt, info.alu.op_sltu, info.alu.op_xor,
         info.alu.op_srl, info.alu.op_sra, info.alu.op_or, info.alu.op_and}
            = ALU_OP_W'(1) << (ALU_OP_W - 1 - idx);
        return info;
    endfunction

    function automatic dec_info_u div_info(input int idx);
        dec_info_u info;
        info = '0;
        info.div.grp = GRP_DIV;
        {info.div.op_div, info.div.op_divu, info.div.op_rem, info.div.op_remu} = 4'b1000 >> idx;
        return info;
    endfunction

    // reference for the rv32i alu ops
    function automatic logic [XLEN-1:0] alu_model(input int idx, input logic use_imm,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input logic [XLEN-1:0] imm,
                                                  input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] src2;
        logic [XLEN-1:0] res;
        src2 = use_imm ? imm : b;
        case (idx)
            OP_LUI:   res = imm;
            OP_AUIPC: res = pc + imm;
            OP_ADD:   res = a + src2;
            OP_SUB:   res = a - src2;
            OP_SLL:   res = a << src2[SHAMT_W-1:0];
            OP_SLT:   res = ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
            OP_SLTU:  res = (a < src2) ? 32'd1 : 32'd0;
            OP_XOR:   res = a ^ src2;
            OP_SRL:   res = a >> src2[SHAMT_W-1:0];
            OP_SRA:   res = $signed(a) >>> src2[SHAMT_W-1:0];
            OP_OR:    res = a | src2;
            OP_AND:   res = a & src2;
            default:  res = '0;
        endcase
        return res;
    endfunction

    // rv32m division rules with both special cases
    function automatic logic [XLEN-1:0] div_model(input int idx, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        res;
        sa = a;
        sb = b;
        if (b == '0) begin
            res = (idx == OP_DIV || idx == OP_DIVU) ? {XLEN{1'b1}} : a;
        end else if (a == MOST_NEG && b == {XLEN{1'b1}} && idx == OP_DIV) begin
            res = MOST_NEG;
        end else if (a == MOST_NEG && b == {XLEN{1'b1}} && idx == OP_REM) begin
            res = '0;
        end else begin
            case (idx)
                OP_DIV:  res = sa / sb;
                OP_DIVU: res = a / b;
                OP_REM:  res = sa % sb;
                OP_REMU: res = a % b;
                default: res = '0;
            endcase
        end
        return res;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rand_rd();
        return REG_ADDR_W'($urandom_range(31, 1));
    endfunction

    // sign-extended 12-bit immediate
    function automatic logic [XLEN-1:0] rand_imm12();
        logic [11:0] raw;
        raw = 12'($urandom);
        return {{(XLEN-12){raw[11]}}, raw};
    endfunction

    task automatic set_idle();
        dec_info = '0;
        dec_info.alu.grp = GRP_NONE;
        dec_imm = '0;
        dec_pc = '0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
            set_idle();
            @(negedge clk);
            check_value("idle hold flag", XLEN'(hold), 0);
            check_value("idle div write enable", XLEN'(md_we), 0);
            check_value("idle alu write enable", XLEN'(alu_we), 0);
        end
    endtask

    task automatic run_alu(input int idx, input logic use_imm, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
                           input logic [XLEN-1:0] pc, input logic [REG_ADDR_W-1:0] rd_w);
        logic [XLEN-1:0] exp;
        string           tag;
        @(posedge clk);
        #DRIVE_DLY;
        dec_info = alu_info(idx, use_imm);
        rs1 = a;
        rs2 = b;
        dec_imm = imm;
        dec_pc = pc;
        rd = rd_w;
        exp = alu_model(idx, use_imm, a, b, imm, pc);
        tag = $sformatf("%s%s", alu_names[idx], use_imm ? " imm" : "");
        @(negedge clk);
        check_value($sformatf("%s result", tag), alu_wdata, exp);
        check_value($sformatf("%s write enable", tag), XLEN'(alu_we), 1);
        check_value($sformatf("%s destination", tag), XLEN'(alu_waddr), XLEN'(rd_w));
        check_value($sformatf("%s hold flag", tag), XLEN'(hold), 0);
        check_value($sformatf("%s div write enable", tag), XLEN'(md_we), 0);
    endtask

    // inputs stay put until the write-back shows up
    task automatic run_div(input int idx, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                           input logic [REG_ADDR_W-1:0] rd_w);
        logic [XLEN-1:0] exp;
        int              waited;
        @(posedge clk);
        #DRIVE_DLY;
        dec_info = div_info(idx);
        rs1 = a;
        rs2 = b;
        dec_imm = $urandom;
        dec_pc = $urandom;
        rd = rd_w;
        exp = div_model(idx, a, b);
        waited = 0;
        @(negedge clk);
        while (md_we !== 1'b1) begin
            check_value($sformatf("%s hold flag while busy", div_names[idx]), XLEN'(hold), 1);
            check_value($sformatf("%s alu write enable", div_names[idx]), XLEN'(alu_we), 0);
            waited++;
            if (waited > DIV_MAX_WAIT) begin
                $display("%s of %h by %h gave no write-back within %0d cycles",
                         div_names[idx], a, b, DIV_MAX_WAIT);
                $display("TEST FAIL");
                $fatal(1, "division did not complete");
            end
            @(negedge clk);
        end
        check_value($sformatf("%s %h by %h result", div_names[idx], a, b), md_wdata, exp);
        check_value($sformatf("%s destination", div_names[idx]), XLEN'(md_waddr), XLEN'(rd_w));
        check_value($sformatf("%s hold flag at write-back", div_names[idx]), XLEN'(hold), 0);
    endtask

    task automatic test_reset();
        expect_quiet(3);
    endtask

    task automatic test_alu_reg(input int n);
        int idx;
        // shift amounts above 31 must wrap to the low bits
        run_alu(OP_SLL, 1'b0, 32'h1, 32'd33, '0, '0, 5'd3);
        run_alu(OP_SRA, 1'b0, MOST_NEG, 32'd36, '0, '0, 5'd4);
        run_alu(OP_SRL, 1'b0, MOST_NEG, 32'hffff_ffe4, '0, '0, 5'd5);
        for (int i = 0; i < n; i++) begin
            idx = $urandom_range(OP_AND, OP_ADD);
            run_alu(idx, 1'b0, $urandom, $urandom, $urandom, $urandom, rand_rd());
        end
    endtask

    task automatic test_alu_imm(input int n);
        int idx;
        for (int i = 0; i < n; i++) begin
            idx = $urandom_range(OP_AND, OP_LUI);
            if (idx == OP_LUI || idx == OP_AUIPC) begin
                run_alu(idx, 1'b0, $urandom, $urandom, {20'($urandom), 12'h000},
                        $urandom, rand_rd());
            end else begin
                run_alu(idx, 1'b1, $urandom, $urandom, rand_imm12(), $urandom, rand_rd());
            end
        end
    endtask

    task automatic test_div_random(input int n);
        logic [XLEN-1:0] divisor;
        for (int i = 0; i < n; i++) begin
            // narrower divisors now and then for larger quotients
            divisor = $urandom >> $urandom_range(30, 0);
            run_div($urandom_range(3, 0), $urandom, divisor, rand_rd());
            expect_quiet(2);
        end
    endtask

    task automatic test_div_corners();
        for (int idx = 0; idx < 4; idx++) begin
            run_div(idx, 32'hdead_beef, '0, rand_rd());
            run_div(idx, MOST_NEG, 32'hffff_ffff, rand_rd());
            run_div(idx, 32'hffff_fff9, 32'd2, rand_rd());
            run_div(idx, 32'd7, 32'hffff_fffe, rand_rd());
            run_div(idx, 32'hffff_fff9, 32'hffff_fffe, rand_rd());
        end
        expect_quiet(2);
    endtask

    task automatic test_back_to_back(input int n);
        logic [REG_ADDR_W-1:0] rd_first;
        for (int i = 0; i < n; i++) begin
            rd_first = REG_ADDR_W'($urandom_range(30, 1));
            run_div($urandom_range(3, 0), $urandom, $urandom >> 8, rd_first);
            run_alu($urandom_range(OP_AND, OP_ADD), 1'b0, $urandom, $urandom, $urandom,
                    $urandom, rand_rd());
            run_div($urandom_range(3, 0), $urandom, $urandom >> 16, rd_first + REG_ADDR_W'(1));
            expect_quiet(2);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        set_idle();
        wait (rst === 1'b0);
        test_reset();
        test_alu_reg(150);
        test_alu_imm(120);
        test_div_random(44);
        test_div_corners();
        test_back_to_back(4);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: list.f
rtl/exu_cfg_pkg.sv
rtl/exu_dec_pkg.sv
rtl/exu_dispatch.sv
rtl/exu_alu.sv
rtl/exu_div_ctrl.sv
rtl/exu_div.sv
rtl/exu.sv
verification/tb_clk_gen.sv
verification/tb_exu.sv

// File: run.sh
#!/bin/sh
# build and run the exu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_exu_sim

verilator --binary --timing --assert -f list.f --top-module tb_exu -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, no pass line in $LOG"
exit 1
